// File: hw/addr_params.svh
// Widths, thread count and address map of the write-address translation stage.
// Included by the package and by every module that sizes a port or a window.

`ifndef ADDR_PARAMS_SVH
`define ADDR_PARAMS_SVH

// Data address and offset width
`define ADDR_WORD_WIDTH      16

// Barrel threads and the width of a thread number
`define ADDR_THREAD_COUNT    8
`define ADDR_THREAD_WIDTH    3
`define ADDR_INITIAL_THREAD  0

// High memory is shared by all threads and never translated
`define ADDR_H_BASE          16'hF000
`define ADDR_H_DEPTH         16'h0800

// The two I/O windows, which sit above the end of high memory
`define ADDR_A_IO_BASE       16'hFC00
`define ADDR_A_IO_COUNT      8
`define ADDR_B_IO_BASE       16'hFE00
`define ADDR_B_IO_COUNT      8

// One Wishbone word per thread entry
`define ADDR_WB_ADR_WIDTH    3

`endif

// File: hw/addr_pkg.sv
// Bundled types for the address path, the offset table and the Wishbone port.
// Referenced by scoped name from the RTL and the testbench.
`default_nettype none

`include "addr_params.svh"

package addr_pkg;

    typedef struct packed {
        logic                              valid;
        logic [`ADDR_WORD_WIDTH-1:0]       addr;
    } addr_req_t;

    typedef struct packed {
        logic                              valid;
        logic [`ADDR_WORD_WIDTH-1:0]       addr;
    } addr_rsp_t;

    typedef struct packed {
        logic                              en;
        logic [`ADDR_THREAD_WIDTH-1:0]     thread;
        logic [`ADDR_WORD_WIDTH-1:0]       offset;
    } offset_wr_t;

    // Master to slave, classic cycles only
    typedef struct packed {
        logic                              cyc;
        logic                              stb;
        logic                              we;
        logic [`ADDR_WB_ADR_WIDTH-1:0]     adr;
        logic [`ADDR_WORD_WIDTH-1:0]       dat;
    } wb_req_t;

    typedef struct packed {
        logic                              ack;
        logic [`ADDR_WORD_WIDTH-1:0]       dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

// File: hw/address_decoder.sv
// Registered window hit for one contiguous address range.
// Set ADDR_BASE and ADDR_COUNT per instance; hit follows addr by one clock.
`timescale 1ns/10ps
`default_nettype none

`include "addr_params.svh"

module address_decoder #(
    parameter logic [`ADDR_WORD_WIDTH-1:0] ADDR_BASE  = '0,
    parameter int unsigned                 ADDR_COUNT = 1
) (
    input  logic                        clock,
    input  logic                        arst_n,
    input  logic [`ADDR_WORD_WIDTH-1:0] addr,
    output logic                        hit
);
    // One bit wider so a window ending at the top of memory cannot wrap
    localparam logic [`ADDR_WORD_WIDTH:0] LIMIT =
        (`ADDR_WORD_WIDTH+1)'(ADDR_BASE) + (`ADDR_WORD_WIDTH+1)'(ADDR_COUNT);

    logic in_window;

    assign in_window = (addr >= ADDR_BASE) && ({1'b0, addr} < LIMIT);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            hit <= 1'b0;
        end else begin
            hit <= in_window;
        end
    end

endmodule

`default_nettype wire

// File: hw/thread_counter.sv
// Thread number of the barrel pipeline.
// Starts at the initial thread after reset and steps by one every clock.
`timescale 1ns/10ps
`default_nettype none

`include "addr_params.svh"

module thread_counter (
    input  logic                          clock,
    input  logic                          arst_n,
    output logic [`ADDR_THREAD_WIDTH-1:0] thread
);
    localparam logic [`ADDR_THREAD_WIDTH-1:0] LAST_THREAD =
        `ADDR_THREAD_WIDTH'(`ADDR_THREAD_COUNT - 1);
    localparam logic [`ADDR_THREAD_WIDTH-1:0] FIRST_THREAD =
        `ADDR_THREAD_WIDTH'(`ADDR_INITIAL_THREAD);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            thread <= FIRST_THREAD;
        end else if (thread == LAST_THREAD) begin
            // Wrap explicitly, the thread count need not be a power of two
            thread <= '0;
        end else begin
            thread <= thread + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/offset_table.sv
// Per-thread offset registers, cleared at reset.
// One write port from the bus side and two registered read ports,
// one for the translation pipeline and one for bus read-back.
`timescale 1ns/10ps
`default_nettype none

`include "addr_params.svh"

module offset_table (
    input  logic                          clock,
    input  logic                          arst_n,
    input  addr_pkg::offset_wr_t          wr,
    input  logic [`ADDR_THREAD_WIDTH-1:0] rd_thread,
    output logic [`ADDR_WORD_WIDTH-1:0]   rd_offset,
    input  logic [`ADDR_THREAD_WIDTH-1:0] bus_thread,
    output logic [`ADDR_WORD_WIDTH-1:0]   bus_offset
);
    logic [`ADDR_WORD_WIDTH-1:0] offsets [`ADDR_THREAD_COUNT];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `ADDR_THREAD_COUNT; i++) begin
                offsets[i] <= '0;
            end
        end else if (wr.en) begin
            offsets[wr.thread] <= wr.offset;
        end
    end

    // A write lands on the same edge, so reads see it from the next cycle
    always_ff @(posedge clock) begin
        rd_offset  <= offsets[rd_thread];
        bus_offset <= offsets[bus_thread];
    end

endmodule

`default_nettype wire

// File: hw/addressing.sv
// Two-stage translation of a data address into the current thread's private data.
// Stage 1 captures the address and the thread's offset; stage 2 adds them,
// or passes the address through when use_raw_addr is set.
// use_raw_addr must already be aligned with stage 1.
`timescale 1ns/10ps
`default_nettype none

`include "addr_params.svh"

module addressing (
    input  logic                          clock,
    input  logic                          arst_n,
    input  logic                          use_raw_addr,
    input  addr_pkg::addr_req_t           req,
    input  addr_pkg::offset_wr_t          offset_wr,
    input  logic [`ADDR_THREAD_WIDTH-1:0] bus_thread,
    output logic [`ADDR_WORD_WIDTH-1:0]   bus_offset,
    output addr_pkg::addr_rsp_t           rsp
);
    logic [`ADDR_THREAD_WIDTH-1:0] thread;
    logic [`ADDR_WORD_WIDTH-1:0]   thread_offset;
    logic                          s1_valid;
    logic [`ADDR_WORD_WIDTH-1:0]   s1_addr;
    logic                          s2_valid;
    logic [`ADDR_WORD_WIDTH-1:0]   s2_addr;

    thread_counter u_thread_counter (
        .clock  (clock),
        .arst_n (arst_n),
        .thread (thread)
    );

    // The registered read port doubles as the stage 1 offset register
    offset_table u_offset_table (
        .clock      (clock),
        .arst_n     (arst_n),
        .wr         (offset_wr),
        .rd_thread  (thread),
        .rd_offset  (thread_offset),
        .bus_thread (bus_thread),
        .bus_offset (bus_offset)
    );

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= req.valid;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clock) begin
        s1_addr <= req.addr;
        // Sum wraps at the word width
        s2_addr <= use_raw_addr ? s1_addr : s1_addr + thread_offset;
    end

    assign rsp = '{valid: s2_valid, addr: s2_addr};

endmodule

`default_nettype wire

// File: hw/addressing_d.sv
// Translation stage for the data write address.
// High memory and both I/O windows stay untranslated; everything else gets
// the thread offset. Write enable decoding happens on the bus side.
`timescale 1ns/10ps
`default_nettype none

`include "addr_params.svh"

module addressing_d (
    input  logic                          clock,
    input  logic                          arst_n,
    input  addr_pkg::addr_req_t           req,
    input  addr_pkg::offset_wr_t          offset_wr,
    input  logic [`ADDR_THREAD_WIDTH-1:0] bus_thread,
    output logic [`ADDR_WORD_WIDTH-1:0]   bus_offset,
    output addr_pkg::addr_rsp_t           rsp
);
    logic in_high_mem;
    logic in_a_io;
    logic in_b_io;
    logic use_raw_addr;

    address_decoder #(
        .ADDR_BASE  (`ADDR_H_BASE),
        .ADDR_COUNT (`ADDR_H_DEPTH)
    ) u_high_mem (
        .clock  (clock),
        .arst_n (arst_n),
        .addr   (req.addr),
        .hit    (in_high_mem)
    );

    address_decoder #(
        .ADDR_BASE  (`ADDR_A_IO_BASE),
        .ADDR_COUNT (`ADDR_A_IO_COUNT)
    ) u_a_io (
        .clock  (clock),
        .arst_n (arst_n),
        .addr   (req.addr),
        .hit    (in_a_io)
    );

    address_decoder #(
        .ADDR_BASE  (`ADDR_B_IO_BASE),
        .ADDR_COUNT (`ADDR_B_IO_COUNT)
    ) u_b_io (
        .clock  (clock),
        .arst_n (arst_n),
        .addr   (req.addr),
        .hit    (in_b_io)
    );

    // An address in any of the three windows passes through untranslated
    assign use_raw_addr = in_high_mem | in_a_io | in_b_io;

    addressing u_addressing (
        .clock        (clock),
        .arst_n       (arst_n),
        .use_raw_addr (use_raw_addr),
        .req          (req),
        .offset_wr    (offset_wr),
        .bus_thread   (bus_thread),
        .bus_offset   (bus_offset),
        .rsp          (rsp)
    );

endmodule

`default_nettype wire

// File: hw/wb_offset_port.sv
// Wishbone classic slave for loading and reading back the thread offsets.
// Each request gets a single ack one clock later; adr selects the thread.
`timescale 1ns/10ps
`default_nettype none

`include "addr_params.svh"

module wb_offset_port (
    input  logic                          clock,
    input  logic                          arst_n,
    input  addr_pkg::wb_req_t             wb_req,
    output addr_pkg::wb_rsp_t             wb_rsp,
    output addr_pkg::offset_wr_t          offset_wr,
    output logic [`ADDR_THREAD_WIDTH-1:0] bus_thread,
    input  logic [`ADDR_WORD_WIDTH-1:0]   bus_offset
);
    logic ack_q;
    logic new_req;

    // A request counts once, the cycle it shows up before our ack
    assign new_req = wb_req.cyc & wb_req.stb & ~ack_q;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= new_req;
        end
    end

    assign offset_wr = '{en: new_req & wb_req.we, thread: wb_req.adr, offset: wb_req.dat};

    // Table read port is registered, so its data lines up with the ack
    assign bus_thread = wb_req.adr;
    assign wb_rsp     = '{ack: ack_q, dat: bus_offset};

endmodule

`default_nettype wire

// File: hw/addr_xlate_top.sv
// Top level of the write-address translation stage.
// Address requests flow through with a fixed two-clock latency; the offset
// table is loaded and read over the Wishbone port.
`timescale 1ns/10ps
`default_nettype none

`include "addr_params.svh"

module addr_xlate_top (
    input  logic                clock,
    input  logic                arst_n,
    input  addr_pkg::addr_req_t req,
    output addr_pkg::addr_rsp_t rsp,
    input  addr_pkg::wb_req_t   wb_req,
    output addr_pkg::wb_rsp_t   wb_rsp
);
    addr_pkg::offset_wr_t          offset_wr;
    logic [`ADDR_THREAD_WIDTH-1:0] bus_thread;
    logic [`ADDR_WORD_WIDTH-1:0]   bus_offset;

    wb_offset_port u_wb_offset_port (
        .clock      (clock),
        .arst_n     (arst_n),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .offset_wr  (offset_wr),
        .bus_thread (bus_thread),
        .bus_offset (bus_offset)
    );

    addressing_d u_addressing_d (
        .clock      (clock),
        .arst_n     (arst_n),
        .req        (req),
        .offset_wr  (offset_wr),
        .bus_thread (bus_thread),
        .bus_offset (bus_offset),
        .rsp        (rsp)
    );

endmodule

`default_nettype wire

// File: sim/addr_xlate_checker.sv
// Concurrent checks on the address pipeline and the Wishbone handshake.
// Bound into addr_xlate_top; assert_failures counts every failed assertion.
`timescale 1ns/10ps
`default_nettype none

module addr_xlate_checker (
    input logic                clock,
    input logic                arst_n,
    input addr_pkg::addr_req_t req,
    input addr_pkg::addr_rsp_t rsp,
    input addr_pkg::wb_req_t   wb_req,
    input addr_pkg::wb_rsp_t   wb_rsp
);
    int assert_failures = 0;

    // Output valid is the input valid delayed by exactly two clocks
    valid_latency: assert property (@(posedge clock) disable iff (!arst_n)
        rsp.valid == $past(req.valid, 2))
        else begin
            assert_failures++;
            $error("rsp.valid does not follow req.valid by two clocks");
        end

    ack_in_cycle: assert property (@(posedge clock) disable iff (!arst_n)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
        else begin
            assert_failures++;
            $error("ack raised outside a bus cycle");
        end

    single_ack: assert property (@(posedge clock) disable iff (!arst_n)
        wb_rsp.ack |=> !wb_rsp.ack)
        else begin
            assert_failures++;
            $error("ack held for two clocks");
        end

    quiet_in_reset: assert property (@(posedge clock)
        !arst_n |-> (!wb_rsp.ack && !rsp.valid))
        else begin
            assert_failures++;
            $error("ack or rsp.valid high during reset");
        end

endmodule

`default_nettype wire

// File: sim/addr_xlate_tb.sv
// Testbench for addr_xlate_top. Loads offsets over Wishbone, then runs a table
// of addresses and a random stream, comparing each output two clocks later
// against a model of the thread number and the offset table.
`timescale 1ns/10ps
`default_nettype none

`include "addr_params.svh"

module addr_xlate_tb;

    localparam int          RESET_CYCLES = 16;
    localparam int          TABLE_LEN    = 20;
    localparam int          RAND_COUNT   = 200;
    localparam logic [31:0] SEED         = 32'hcc11_7530;
    // Reset, zero-offset pass, bus writes and reads, offset table pass, random pass
    localparam int STIM_CYCLES = RESET_CYCLES + 2 + (10 + 2) + 6 * `ADDR_THREAD_COUNT
                                 + (TABLE_LEN + 2) + (RAND_COUNT + 2);
    localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES;

    typedef struct packed {
        logic [`ADDR_WORD_WIDTH-1:0] addr;
        logic                        raw;
    } vector_t;

    logic                clock;
    logic                arst_n;
    addr_pkg::addr_req_t req;
    addr_pkg::addr_rsp_t rsp;
    addr_pkg::wb_req_t   wb_req;
    addr_pkg::wb_rsp_t   wb_rsp;

    logic [`ADDR_WORD_WIDTH-1:0] model_offset [`ADDR_THREAD_COUNT];
    int                          model_thread;
    addr_pkg::addr_rsp_t         exp_q [$];
    logic [31:0]                 rng;
    int                          cycle_count = 0;
    int                          check_count = 0;
    int                          error_count = 0;

    // Ten low addresses, then the edges of each window. The words after the
    // I/O windows lie above high memory (F000 to F7FF) and are translated
    vector_t vectors [TABLE_LEN] = '{
        '{16'h0000, 1'b0}, '{16'h0001, 1'b0}, '{16'h00ff, 1'b0}, '{16'h1234, 1'b0},
        '{16'h4000, 1'b0}, '{16'h7fff, 1'b0}, '{16'h8000, 1'b0}, '{16'habcd, 1'b0},
        '{16'heffe, 1'b0}, '{16'hefff, 1'b0}, '{16'hf000, 1'b1}, '{16'hf001, 1'b1},
        '{16'hf7ff, 1'b1}, '{16'hf800, 1'b0}, '{16'hfc00, 1'b1}, '{16'hfc07, 1'b1},
        '{16'hfc08, 1'b0}, '{16'hfe00, 1'b1}, '{16'hfe07, 1'b1}, '{16'hfe08, 1'b0}
    };

    addr_xlate_top uut (
        .clock  (clock),
        .arst_n (arst_n),
        .req    (req),
        .rsp    (rsp),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    bind addr_xlate_top addr_xlate_checker u_checker (
        .clock  (clock),
        .arst_n (arst_n),
        .req    (req),
        .rsp    (rsp),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    always #50 clock = ~clock;

    // Thread model: starts at the initial thread and steps once per clock
    always @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            model_thread <= `ADDR_INITIAL_THREAD;
        end else begin
            model_thread <= (model_thread + 1) % `ADDR_THREAD_COUNT;
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: no result after %0d clock cycles", TIMEOUT_CYCLES);
            error_count++;
            finish_run();
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic in_window(input logic [15:0] addr, input int base, input int count);
        return (int'(addr) >= base) && (int'(addr) < base + count);
    endfunction

    function automatic logic is_raw(input logic [15:0] addr);
        return in_window(addr, `ADDR_H_BASE, `ADDR_H_DEPTH)
            || in_window(addr, `ADDR_A_IO_BASE, `ADDR_A_IO_COUNT)
            || in_window(addr, `ADDR_B_IO_BASE, `ADDR_B_IO_COUNT);
    endfunction

    // One clock: check the result of the request from two clocks ago, drive the next
    task automatic step(input logic valid, input logic [15:0] addr, input logic raw);
        addr_pkg::addr_rsp_t expected;
        @(posedge clock);
        #5;
        if (exp_q.size() == 2) begin
            expected = exp_q.pop_front();
            check_count++;
            if (rsp.valid !== expected.valid) begin
                error_count++;
                $display("CHECK FAILED at %0t: rsp.valid %b, expected %b",
                         $time, rsp.valid, expected.valid);
            end else if (expected.valid && rsp.addr !== expected.addr) begin
                error_count++;
                $display("CHECK FAILED at %0t: rsp.addr %h, expected %h",
                         $time, rsp.addr, expected.addr);
            end
        end
        req = '{valid: valid, addr: addr};
        expected.valid = valid;
        expected.addr  = raw ? addr : addr + model_offset[model_thread];
        exp_q.push_back(expected);
    endtask

    task automatic drain();
        step(1'b0, '0, 1'b0);
        step(1'b0, '0, 1'b0);
        exp_q.delete();
    endtask

    task automatic wb_access(input logic we, input logic [2:0] adr,
                             input logic [15:0] wdata, output logic [15:0] rdata);
        int waited;
        @(posedge clock);
        #5;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdata};
        waited = 0;
        do begin
            @(posedge clock);
            #5;
            waited++;
        end while (!wb_rsp.ack && waited < 4);
        rdata = wb_rsp.dat;
        check_count++;
        if (!wb_rsp.ack) begin
            error_count++;
            $display("No bus ack for thread %0d at %0t", adr, $time);
        end else if (waited != 1) begin
            error_count++;
            $display("CHECK FAILED at %0t: ack after %0d cycles, expected 1", $time, waited);
        end
        // The master takes the ack on this edge and ends the cycle
        @(posedge clock);
        #5;
        wb_req = '0;
        check_count++;
        if (wb_rsp.ack) begin
            error_count++;
            $display("CHECK FAILED at %0t: second ack for thread %0d", $time, adr);
        end
    endtask

    task automatic finish_run();
        error_count += uut.u_checker.assert_failures;
        $display("Checks: %0d, errors: %0d (assertion failures: %0d)",
                 check_count, error_count, uut.u_checker.assert_failures);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    initial begin
        logic [15:0] rdata;
        logic [15:0] value;
        logic [15:0] addr;
        clock  = 1'b0;
        arst_n = 1'b1;
        req    = '0;
        wb_req = '0;
        rng    = SEED;
        for (int t = 0; t < `ADDR_THREAD_COUNT; t++) begin
            model_offset[t] = '0;
        end
        #1;
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #5;
        arst_n = 1'b1;

        check_count++;
        if (rsp.valid || wb_rsp.ack) begin
            error_count++;
            $display("CHECK FAILED at %0t: rsp.valid or ack high after reset", $time);
        end

        // All offsets are zero, so low addresses come out unchanged
        for (int i = 0; i < 10; i++) begin
            step(1'b1, vectors[i].addr, vectors[i].raw);
        end
        drain();

        for (int t = 0; t < `ADDR_THREAD_COUNT; t++) begin
            rng   = xorshift32(rng);
            value = (rng[15:0] == '0) ? 16'h0001 : rng[15:0];
            wb_access(1'b1, 3'(t), value, rdata);
            model_offset[t] = value;
        end
        for (int t = 0; t < `ADDR_THREAD_COUNT; t++) begin
            wb_access(1'b0, 3'(t), '0, rdata);
            check_count++;
            if (rdata !== model_offset[t]) begin
                error_count++;
                $display("CHECK FAILED at %0t: thread %0d offset read %h, expected %h",
                         $time, t, rdata, model_offset[t]);
            end
        end

        for (int i = 0; i < TABLE_LEN; i++) begin
            step(1'b1, vectors[i].addr, vectors[i].raw);
        end
        drain();

        // Random stream, mixing window hits, free addresses and idle cycles
        for (int i = 0; i < RAND_COUNT; i++) begin
            rng = xorshift32(rng);
            if (rng[2:0] == 3'd0) begin
                step(1'b0, rng[31:16], 1'b0);
            end else begin
                case (rng[4:3])
                    2'd0:    addr = `ADDR_H_BASE + 16'(rng[15:4]);
                    2'd1:    addr = (rng[9] ? `ADDR_A_IO_BASE : `ADDR_B_IO_BASE) + 16'(rng[8:5]);
                    default: addr = rng[31:16];
                endcase
                step(1'b1, addr, is_raw(addr));
            end
        end
        drain();

        finish_run();
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+hw
hw/addr_pkg.sv
hw/address_decoder.sv
hw/thread_counter.sv
hw/offset_table.sv
hw/addressing.sv
hw/addressing_d.sv
hw/wb_offset_port.sv
hw/addr_xlate_top.sv
sim/addr_xlate_checker.sv
sim/addr_xlate_tb.sv

// File: Makefile
# Verilator build and run for the write-address translation stage.
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= addr_xlate_tb
FILELIST  ?= project.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
